// File: Bender.yml
package:
  name: vec_system

sources:
  - source/vsys_pkg.sv
  - source/mem_spill.sv
  - source/narrow_upsizer.sv
  - source/vec_unit.sv
  - source/inval_filter.sv
  - source/mem_arbiter.sv
  - source/vec_system.sv
  - target: test
    files:
      - test/tb_mem_model.sv
      - test/tb_vec_system.sv

// File: source/inval_filter.sv
// Accelerator write-path filter that sends the core a line invalidation before each write
module inval_filter import vsys_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 en_i,
  input  mem_req_t             slv_req_i,
  input  logic                 slv_req_valid_i,
  output logic                 slv_req_ready_o,
  output mem_req_t             mst_req_o,
  output logic                 mst_req_valid_o,
  input  logic                 mst_req_ready_i,
  output logic [AddrWidth-1:0] inval_addr_o,
  output logic                 inval_valid_o,
  input  logic                 inval_ready_i
);

  // Invalidation of the current write already taken by the core
  logic sent_q;
  logic need_inval;

  // A write under coherence waits for its invalidation
  assign need_inval = en_i & slv_req_i.we & ~sent_q;

  assign inval_valid_o = slv_req_valid_i & need_inval;
  assign inval_addr_o  = slv_req_i.addr & ~AddrWidth'(LineBytes - 1);

  assign mst_req_o       = slv_req_i;
  assign mst_req_valid_o = slv_req_valid_i & ~need_inval;
  assign slv_req_ready_o = mst_req_ready_i & ~need_inval;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sent_q <= 1'b0;
    end else if (slv_req_valid_i && slv_req_ready_o) begin
      sent_q <= 1'b0;
    end else if (inval_valid_o && inval_ready_i) begin
      sent_q <= 1'b1;
    end
  end

  // A stalled invalidation keeps its line address until the core takes it
  a_inval_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    inval_valid_o && !inval_ready_i |=> inval_valid_o && $stable(inval_addr_o));

endmodule : inval_filter

// File: source/mem_arbiter.sv
// Round-robin merge of the core and accelerator request channels onto one memory port
module mem_arbiter import vsys_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  mem_req_t [1:0] req_i,
  input  logic     [1:0] req_valid_i,
  output logic     [1:0] req_ready_o,
  output mem_rsp_t       rsp_o,
  output logic     [1:0] rsp_valid_o,
  input  logic     [1:0] rsp_ready_i,
  output mem_req_t       mem_req_o,
  output logic           mem_req_valid_o,
  input  logic           mem_req_ready_i,
  input  mem_rsp_t       mem_rsp_i,
  input  logic           mem_rsp_valid_i,
  output logic           mem_rsp_ready_o
);

  logic busy_q;
  logic owner_q;
  logic prio_q;
  logic sel;
  logic grant_valid;
  logic grant_ready;
  logic rsp_valid;
  logic rsp_ready;

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Priority master wins, otherwise the other one
  assign sel         = req_valid_i[prio_q] ? prio_q : ~prio_q;
  assign grant_valid = ~busy_q & |req_valid_i;

  always_comb begin
    req_ready_o      = '0;
    req_ready_o[sel] = grant_valid & grant_ready;
  end

  mem_spill #(
    .payload_t (mem_req_t)
  ) i_req_spill (
    .clk_i       (clk_i          ),
    .rst_n_i     (rst_n_i        ),
    .in_i        (req_i[sel]     ),
    .in_valid_i  (grant_valid    ),
    .in_ready_o  (grant_ready    ),
    .out_o       (mem_req_o      ),
    .out_valid_o (mem_req_valid_o),
    .out_ready_i (mem_req_ready_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////

  mem_spill #(
    .payload_t (mem_rsp_t)
  ) i_rsp_spill (
    .clk_i       (clk_i          ),
    .rst_n_i     (rst_n_i        ),
    .in_i        (mem_rsp_i      ),
    .in_valid_i  (mem_rsp_valid_i),
    .in_ready_o  (mem_rsp_ready_o),
    .out_o       (rsp_o          ),
    .out_valid_o (rsp_valid      ),
    .out_ready_i (rsp_ready      )
  );

  always_comb begin
    rsp_valid_o          = '0;
    rsp_valid_o[owner_q] = rsp_valid;
  end

  assign rsp_ready = rsp_ready_i[owner_q];

  // Grant held until the owner takes its response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      owner_q <= 1'b0;
      prio_q  <= 1'b0;
    end else if (grant_valid && grant_ready) begin
      busy_q  <= 1'b1;
      owner_q <= sel;
    end else if (rsp_valid && rsp_ready) begin
      busy_q <= 1'b0;
      prio_q <= ~owner_q;
    end
  end

  a_rsp_only_when_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_rsp_valid_i |-> busy_q);

endmodule : mem_arbiter

// File: source/mem_spill.sv
// One-entry valid/ready spill register for any payload type, used on both arbiter paths
module mem_spill #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t in_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output payload_t out_o,
  output logic     out_valid_o,
  input  logic     out_ready_i
);

  logic     full_q;
  payload_t data_q;

  // Accept while empty or while the held entry leaves
  assign in_ready_o  = ~full_q | out_ready_i;
  assign out_valid_o = full_q;
  assign out_o       = data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (in_ready_o) begin
      full_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_i;
    end
  end

  a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_o));

endmodule : mem_spill

// File: source/narrow_upsizer.sv
// Maps 32-bit core accesses onto the 64-bit memory channel and returns the addressed half
module narrow_upsizer import vsys_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  core_req_t core_req_i,
  input  logic      core_req_valid_i,
  output logic      core_req_ready_o,
  output core_rsp_t core_rsp_o,
  output logic      core_rsp_valid_o,
  input  logic      core_rsp_ready_i,
  output mem_req_t  wide_req_o,
  output logic      wide_req_valid_o,
  input  logic      wide_req_ready_i,
  input  mem_rsp_t  wide_rsp_i,
  input  logic      wide_rsp_valid_i,
  output logic      wide_rsp_ready_o
);

  logic hi_q;
  logic pend_q;
  logic hi;

  // Bit 2 picks the upper word of the 64-bit beat
  assign hi = core_req_i.addr[2];

  always_comb begin
    wide_req_o.addr  = {core_req_i.addr[AddrWidth-1:3], 3'b000};
    wide_req_o.we    = core_req_i.we;
    wide_req_o.wdata = hi ? {core_req_i.wdata, {NarrowWidth{1'b0}}}
                          : {{NarrowWidth{1'b0}}, core_req_i.wdata};
    wide_req_o.wstrb = hi ? {core_req_i.wstrb, {NarrowStrbWidth{1'b0}}}
                          : {{NarrowStrbWidth{1'b0}}, core_req_i.wstrb};
  end

  assign wide_req_valid_o = core_req_valid_i;
  assign core_req_ready_o = wide_req_ready_i;

  assign core_rsp_o.rdata = hi_q ? wide_rsp_i.rdata[WideWidth-1:NarrowWidth]
                                 : wide_rsp_i.rdata[NarrowWidth-1:0];
  assign core_rsp_valid_o = wide_rsp_valid_i;
  assign wide_rsp_ready_o = core_rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hi_q   <= 1'b0;
      pend_q <= 1'b0;
    end else if (core_req_valid_i && core_req_ready_o) begin
      hi_q   <= hi;
      pend_q <= 1'b1;
    end else if (core_rsp_valid_o && core_rsp_ready_i) begin
      pend_q <= 1'b0;
    end
  end

  // The arbiter holds its grant until the response is back
  a_one_outstanding : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_req_valid_i && core_req_ready_o |-> !pend_q);

endmodule : narrow_upsizer

// File: source/vec_system.sv
// Top level of the vector subsystem, wiring core ports, vector unit, filter, upsizer and arbiter
module vec_system import vsys_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Narrow core memory channel
  input  core_req_t            core_req_i,
  input  logic                 core_req_valid_i,
  output logic                 core_req_ready_o,
  output core_rsp_t            core_rsp_o,
  output logic                 core_rsp_valid_o,
  input  logic                 core_rsp_ready_i,
  // Accelerator channel
  input  acc_req_t             acc_req_i,
  input  logic                 acc_req_valid_i,
  output logic                 acc_req_ready_o,
  output acc_rsp_t             acc_rsp_o,
  output logic                 acc_rsp_valid_o,
  input  logic                 acc_rsp_ready_i,
  // Coherence
  input  logic                 coh_en_i,
  output logic [AddrWidth-1:0] inval_addr_o,
  output logic                 inval_valid_o,
  input  logic                 inval_ready_i,
  // Wide memory port
  output mem_req_t             mem_req_o,
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  input  mem_rsp_t             mem_rsp_i,
  input  logic                 mem_rsp_valid_i,
  output logic                 mem_rsp_ready_o
);

  // Port 0 core, port 1 accelerator
  mem_req_t [1:0] arb_req;
  logic     [1:0] arb_req_valid;
  logic     [1:0] arb_req_ready;
  mem_rsp_t       arb_rsp;
  logic     [1:0] arb_rsp_valid;
  logic     [1:0] arb_rsp_ready;

  mem_req_t vec_req;
  logic     vec_req_valid;
  logic     vec_req_ready;

  narrow_upsizer i_upsizer (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .core_req_i       (core_req_i      ),
    .core_req_valid_i (core_req_valid_i),
    .core_req_ready_o (core_req_ready_o),
    .core_rsp_o       (core_rsp_o      ),
    .core_rsp_valid_o (core_rsp_valid_o),
    .core_rsp_ready_i (core_rsp_ready_i),
    .wide_req_o       (arb_req[0]      ),
    .wide_req_valid_o (arb_req_valid[0]),
    .wide_req_ready_i (arb_req_ready[0]),
    .wide_rsp_i       (arb_rsp         ),
    .wide_rsp_valid_i (arb_rsp_valid[0]),
    .wide_rsp_ready_o (arb_rsp_ready[0])
  );

  vec_unit i_vec_unit (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .acc_req_i       (acc_req_i       ),
    .acc_req_valid_i (acc_req_valid_i ),
    .acc_req_ready_o (acc_req_ready_o ),
    .acc_rsp_o       (acc_rsp_o       ),
    .acc_rsp_valid_o (acc_rsp_valid_o ),
    .acc_rsp_ready_i (acc_rsp_ready_i ),
    .mem_req_o       (vec_req         ),
    .mem_req_valid_o (vec_req_valid   ),
    .mem_req_ready_i (vec_req_ready   ),
    .mem_rsp_i       (arb_rsp         ),
    .mem_rsp_valid_i (arb_rsp_valid[1]),
    .mem_rsp_ready_o (arb_rsp_ready[1])
  );

  // Responses skip the filter
  inval_filter i_inval_filter (
    .clk_i           (clk_i           ),
    .rst_n_i         (rst_n_i         ),
    .en_i            (coh_en_i        ),
    .slv_req_i       (vec_req         ),
    .slv_req_valid_i (vec_req_valid   ),
    .slv_req_ready_o (vec_req_ready   ),
    .mst_req_o       (arb_req[1]      ),
    .mst_req_valid_o (arb_req_valid[1]),
    .mst_req_ready_i (arb_req_ready[1]),
    .inval_addr_o    (inval_addr_o    ),
    .inval_valid_o   (inval_valid_o   ),
    .inval_ready_i   (inval_ready_i   )
  );

  mem_arbiter i_mem_arbiter (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .req_i           (arb_req        ),
    .req_valid_i     (arb_req_valid  ),
    .req_ready_o     (arb_req_ready  ),
    .rsp_o           (arb_rsp        ),
    .rsp_valid_o     (arb_rsp_valid  ),
    .rsp_ready_i     (arb_rsp_ready  ),
    .mem_req_o       (mem_req_o      ),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_i       (mem_rsp_i      ),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_o (mem_rsp_ready_o)
  );

endmodule : vec_system

// File: source/vec_unit.sv
// Vector accelerator that checks an instruction, then reads, adds and writes one word at a time
module vec_unit import vsys_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  acc_req_t acc_req_i,
  input  logic     acc_req_valid_i,
  output logic     acc_req_ready_o,
  output acc_rsp_t acc_rsp_o,
  output logic     acc_rsp_valid_o,
  input  logic     acc_rsp_ready_i,
  output mem_req_t mem_req_o,
  output logic     mem_req_valid_o,
  input  logic     mem_req_ready_i,
  input  mem_rsp_t mem_rsp_i,
  input  logic     mem_rsp_valid_i,
  output logic     mem_rsp_ready_o
);

  typedef enum logic [2:0] {
    IDLE,
    READ,
    WAIT_READ,
    WRITE,
    WAIT_WRITE,
    RESP
  } state_e;

  state_e               state_q;
  state_e               state_d;
  acc_req_t             req_q;
  logic [LenWidth-1:0]  cnt_q;
  logic [WideWidth-1:0] data_q;
  logic                 err_q;
  logic                 ready_q;
  logic                 accept;
  logic                 bad_instr;
  logic [AddrWidth-1:0] offset;

  assign accept    = acc_req_valid_i & ready_q;
  assign bad_instr = (acc_req_i.len == '0) || (acc_req_i.len > LenWidth'(MaxVecLen)) ||
                     !(acc_req_i.op inside {OP_VADDS, OP_VCOPY});

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:       if (accept) state_d = bad_instr ? RESP : READ;
      READ:       if (mem_req_ready_i) state_d = WAIT_READ;
      WAIT_READ:  if (mem_rsp_valid_i) state_d = WRITE;
      WRITE:      if (mem_req_ready_i) state_d = WAIT_WRITE;
      WAIT_WRITE: if (mem_rsp_valid_i) state_d = (cnt_q + 1'b1 == req_q.len) ? RESP : READ;
      RESP:       if (acc_rsp_ready_i) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      ready_q <= 1'b0;
      cnt_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d == IDLE);
      if (accept) begin
        cnt_q <= '0;
        err_q <= bad_instr;
      end else if (state_q == WAIT_WRITE && mem_rsp_valid_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Instruction and word buffer
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= acc_req_i;
    end
    if (state_q == WAIT_READ && mem_rsp_valid_i) begin
      for (int l = 0; l < WideWidth / NarrowWidth; l++) begin
        data_q[l*NarrowWidth +: NarrowWidth] <= mem_rsp_i.rdata[l*NarrowWidth +: NarrowWidth] +
          ((req_q.op == OP_VADDS) ? req_q.scalar : '0);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Memory and response side
  //////////////////////////////////////////////////////////////////////

  assign offset = AddrWidth'(cnt_q) << 3;

  always_comb begin
    mem_req_o.we    = (state_q == WRITE);
    mem_req_o.addr  = (state_q == WRITE) ? req_q.dst_addr + offset : req_q.src_addr + offset;
    mem_req_o.wdata = data_q;
    mem_req_o.wstrb = '1;
  end

  assign mem_req_valid_o = (state_q == READ) || (state_q == WRITE);
  assign mem_rsp_ready_o = (state_q == WAIT_READ) || (state_q == WAIT_WRITE);

  assign acc_req_ready_o      = ready_q;
  assign acc_rsp_valid_o      = (state_q == RESP);
  assign acc_rsp_o.words_done = cnt_q;
  assign acc_rsp_o.error      = err_q;

  a_cnt_in_range : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    state_q != IDLE |-> cnt_q <= req_q.len);

endmodule : vec_unit

// File: source/vsys_pkg.sv
// Shared widths, opcodes and channel structs of the vector subsystem, imported by every RTL module
package vsys_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and limits
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NarrowWidth = 32;
  localparam int unsigned WideWidth   = 64;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned LineBytes   = 32;
  localparam int unsigned MaxVecLen   = 16;
  localparam int unsigned LenWidth    = 5;

  // One strobe bit per byte
  localparam int unsigned NarrowStrbWidth = NarrowWidth / 8;
  localparam int unsigned WideStrbWidth   = WideWidth / 8;

  //////////////////////////////////////////////////////////////////////
  // Vector opcodes, codes 2 and 3 are illegal
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OP_VADDS = 2'd0,
    OP_VCOPY = 2'd1
  } vec_op_e;

  //////////////////////////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    vec_op_e                op;
    logic [AddrWidth-1:0]   src_addr;
    logic [AddrWidth-1:0]   dst_addr;
    logic [LenWidth-1:0]    len;
    logic [NarrowWidth-1:0] scalar;
  } acc_req_t;

  typedef struct packed {
    logic [LenWidth-1:0] words_done;
    logic                error;
  } acc_rsp_t;

  // Narrow core side
  typedef struct packed {
    logic [AddrWidth-1:0]       addr;
    logic                       we;
    logic [NarrowWidth-1:0]     wdata;
    logic [NarrowStrbWidth-1:0] wstrb;
  } core_req_t;

  typedef struct packed {
    logic [NarrowWidth-1:0] rdata;
  } core_rsp_t;

  // Wide memory side, addresses 8-byte aligned
  typedef struct packed {
    logic [AddrWidth-1:0]     addr;
    logic                     we;
    logic [WideWidth-1:0]     wdata;
    logic [WideStrbWidth-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [WideWidth-1:0] rdata;
  } mem_rsp_t;

endpackage : vsys_pkg

// File: test/tb_mem_model.sv
// Wide memory responder for the testbench, with random stalls and latency and a visible image
module tb_mem_model import vsys_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  mem_req_t req_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  output mem_rsp_t rsp_o,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i
);

  // 256 words of 8 bytes, indexed by address bits 10 to 3
  logic [WideWidth-1:0] image [256];
  logic                 pend_q;
  logic [1:0]           delay_q;

  task automatic fill_random();
    for (int i = 0; i < 256; i++) begin
      image[i] = {$urandom(), $urandom()};
    end
  endtask

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
      pend_q      <= 1'b0;
      delay_q     <= '0;
    end else begin
      if (req_valid_i && req_ready_o) begin
        rsp_o.rdata <= image[req_i.addr[10:3]];
        if (req_i.we) begin
          for (int b = 0; b < WideStrbWidth; b++) begin
            if (req_i.wstrb[b]) begin
              image[req_i.addr[10:3]][b*8 +: 8] = req_i.wdata[b*8 +: 8];
            end
          end
        end
        pend_q      <= 1'b1;
        delay_q     <= 2'($urandom_range(3));
        req_ready_o <= 1'b0;
      end else begin
        // Random stall, and never ready with an access in flight
        req_ready_o <= !pend_q && ($urandom_range(3) != 0);
      end
      if (pend_q && !rsp_valid_o) begin
        if (delay_q == 2'd0) begin
          rsp_valid_o <= 1'b1;
        end else begin
          delay_q <= delay_q - 2'd1;
        end
      end
      if (rsp_valid_o && rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
        pend_q      <= 1'b0;
      end
    end
  end

endmodule : tb_mem_model

// File: test/tb_vec_system.sv
// Testbench top for the vector subsystem, runs the cases file against a memory model and mirror
module tb_vec_system import vsys_pkg::*; ();

  logic        clk = 1'b0;
  logic        rst_n;
  core_req_t   core_req;
  logic        core_req_valid;
  logic        core_req_ready;
  core_rsp_t   core_rsp;
  logic        core_rsp_valid;
  logic        core_rsp_ready;
  acc_req_t    acc_req;
  logic        acc_req_valid;
  logic        acc_req_ready;
  acc_rsp_t    acc_rsp;
  logic        acc_rsp_valid;
  logic        acc_rsp_ready;
  logic        coh_en;
  logic [31:0] inval_addr;
  logic        inval_valid;
  logic        inval_ready;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready;
  mem_rsp_t    mem_rsp;
  logic        mem_rsp_valid;
  logic        mem_rsp_ready;

  int unsigned n_checks;
  int unsigned n_errors;
  int          n_cases;
  bit          cases_loaded;
  bit          vec_busy;
  logic [63:0] mirror [256];
  logic [31:0] inval_q [$];
  logic [31:0] vec_args [6];
  string       lines [$];

  always #4 clk = ~clk;

  vec_system DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .core_req_i (core_req), .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready), .core_rsp_o (core_rsp),
    .core_rsp_valid_o (core_rsp_valid), .core_rsp_ready_i (core_rsp_ready),
    .acc_req_i (acc_req), .acc_req_valid_i (acc_req_valid), .acc_req_ready_o (acc_req_ready),
    .acc_rsp_o (acc_rsp), .acc_rsp_valid_o (acc_rsp_valid), .acc_rsp_ready_i (acc_rsp_ready),
    .coh_en_i (coh_en), .inval_addr_o (inval_addr), .inval_valid_o (inval_valid),
    .inval_ready_i (inval_ready),
    .mem_req_o (mem_req), .mem_req_valid_o (mem_req_valid), .mem_req_ready_i (mem_req_ready),
    .mem_rsp_i (mem_rsp), .mem_rsp_valid_i (mem_rsp_valid), .mem_rsp_ready_o (mem_rsp_ready)
  );

  tb_mem_model i_mem (
    .clk_i (clk), .rst_n_i (rst_n),
    .req_i (mem_req), .req_valid_i (mem_req_valid), .req_ready_o (mem_req_ready),
    .rsp_o (mem_rsp), .rsp_valid_o (mem_rsp_valid), .rsp_ready_i (mem_rsp_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Checks and monitors
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  function automatic void report_counts();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
  endfunction

  always @(posedge clk) begin
    if (inval_valid && inval_ready) begin
      inval_q.push_back(inval_addr);
    end
  end

  // Core-side invalidation acceptance stalls at random
  always @(posedge clk) begin
    inval_ready <= ($urandom_range(3) != 0);
  end

  //////////////////////////////////////////////////////////////////////
  // Core and vector transactions
  //////////////////////////////////////////////////////////////////////

  task automatic core_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    core_req_t   req;
    logic [31:0] half;
    int unsigned idx;
    idx  = addr[10:3];
    half = addr[2] ? mirror[idx][63:32] : mirror[idx][31:0];
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) half[b*8 +: 8] = data[b*8 +: 8];
      end
      if (addr[2]) begin
        mirror[idx][63:32] = half;
      end else begin
        mirror[idx][31:0] = half;
      end
    end
    req.addr  = addr;
    req.we    = we;
    req.wdata = data;
    req.wstrb = strb;
    core_req       <= req;
    core_req_valid <= 1'b1;
    @(posedge clk);
    while (!core_req_ready) @(posedge clk);
    core_req_valid <= 1'b0;
    @(posedge clk);
    while (!core_rsp_valid) @(posedge clk);
    if (!we) begin
      check_value($sformatf("core_rsp_o.rdata @%h", addr), core_rsp.rdata, half);
    end
  endtask

  task automatic vector_op(input logic [1:0] op, input logic [31:0] src, input logic [31:0] dst,
                           input logic [4:0] len, input logic [31:0] scalar, input logic coh);
    acc_req_t    req;
    logic        bad;
    logic [63:0] word;
    int unsigned idx;
    int unsigned n_inval;
    bad = (len == 0) || (len > MaxVecLen) || (op > 2'd1);
    // Expected destination words, lanes wrap modulo 2^32
    if (!bad) begin
      for (int k = 0; k < len; k++) begin
        word = mirror[(src[10:3] + k) % 256];
        if (op == 2'd0) word = {word[63:32] + scalar, word[31:0] + scalar};
        mirror[(dst[10:3] + k) % 256] = word;
      end
    end
    req.op       = vec_op_e'(op);
    req.src_addr = src;
    req.dst_addr = dst;
    req.len      = len;
    req.scalar   = scalar;
    inval_q.delete();
    coh_en        <= coh;
    acc_req       <= req;
    acc_req_valid <= 1'b1;
    @(posedge clk);
    while (!acc_req_ready) @(posedge clk);
    acc_req_valid <= 1'b0;
    @(posedge clk);
    while (!acc_rsp_valid) @(posedge clk);
    check_value("acc_rsp_o.error", acc_rsp.error, bad);
    check_value("acc_rsp_o.words_done", acc_rsp.words_done, bad ? 0 : len);
    if (!bad) begin
      for (int k = 0; k < len; k++) begin
        idx = (dst[10:3] + k) % 256;
        check_value($sformatf("memory word %0d", idx), i_mem.image[idx], mirror[idx]);
      end
    end
    n_inval = (coh && !bad) ? len : 0;
    check_value("invalidation count", inval_q.size(), n_inval);
    for (int k = 0; k < inval_q.size() && k < n_inval; k++) begin
      check_value("inval_addr_o", inval_q[k], (dst + 8 * k) & ~32'(LineBytes - 1));
    end
  endtask

  // Runs one vector op at a time while the main loop keeps issuing core accesses
  initial begin
    forever begin
      wait (vec_busy);
      vector_op(vec_args[0][1:0], vec_args[1], vec_args[2], vec_args[3][4:0], vec_args[4],
                vec_args[5][0]);
      vec_busy = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    string       line;
    byte         kind;
    logic [31:0] f [6];
    rst_n          = 1'b0;
    core_req       = '0;
    core_req_valid = 1'b0;
    core_rsp_ready = 1'b1;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_rsp_ready  = 1'b1;
    coh_en         = 1'b0;
    inval_ready    = 1'b0;
    fd = $fopen("test/vec_system_cases.txt", "r");
    if (fd == 0) begin
      n_errors++;
      $display("Could not open the cases file test/vec_system_cases.txt");
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() > 1 && line[0] != "#") lines.push_back(line);
      end
      $fclose(fd);
    end
    n_cases      = lines.size();
    cases_loaded = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    void'($urandom(93));
    i_mem.fill_random();
    for (int i = 0; i < 256; i++) begin
      mirror[i] = i_mem.image[i];
    end
    foreach (lines[n]) begin
      void'($sscanf(lines[n], "%c %h %h %h %h %h %h", kind, f[0], f[1], f[2], f[3], f[4], f[5]));
      if (kind == "C") begin
        core_access(f[0][0], f[1], f[2], f[3][3:0]);
      end else if (kind == "V") begin
        wait (!vec_busy);
        vec_args = f;
        vec_busy = 1'b1;
      end else begin
        n_errors++;
        $display("Unknown case kind in line: %s", lines[n]);
      end
    end
    wait (!vec_busy);
    @(posedge clk);
    // Whole image, also proves that rejected ops left memory alone
    for (int i = 0; i < 256; i++) begin
      check_value($sformatf("memory word %0d", i), i_mem.image[i], mirror[i]);
    end
    report_counts();
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    wait (cases_loaded);
    #((n_cases + 1) * 2000);
    $display("Timeout, the run did not finish within %0d time units", (n_cases + 1) * 2000);
    report_counts();
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : tb_vec_system

// File: test/vec_system_cases.txt
# C we addr data strb            core access, all fields hex
# V op src dst len scalar coh    vector op, all fields hex, op 0 adds and op 1 copies
C 1 00000700 deadbeef f
C 0 00000700 0 0
C 1 00000704 12345678 5
C 0 00000704 0 0
C 1 0000070c a5a5a5a5 8
C 0 0000070c 0 0
V 0 00000000 00000100 10 00000001 1
C 0 00000708 0 0
C 1 00000710 cafef00d 3
C 0 00000710 0 0
C 0 00000714 0 0
V 1 00000200 00000288 5 00000000 0
C 1 00000720 11111111 f
C 0 00000720 0 0
V 0 00000300 00000380 3 fffffffe 1
V 0 00000000 00000400 0 00000005 1
V 0 00000000 00000400 11 00000005 1
V 3 00000000 00000400 4 00000005 1
C 0 00000700 0 0

// File: vec_system.f
source/vsys_pkg.sv
source/mem_spill.sv
source/narrow_upsizer.sv
source/vec_unit.sv
source/inval_filter.sv
source/mem_arbiter.sv
source/vec_system.sv
test/tb_mem_model.sv
test/tb_vec_system.sv
